//--- include/rnn_defines.svh
`ifndef RNN_DEFINES_SVH
`define RNN_DEFINES_SVH

// Network sizes
`define VOCAB_SIZE   76
`define EMBED_SIZE   4
`define HIDDEN_SIZE  8

// Q8.8 fixed point
`define WORD_W       16
`define FRAC_BITS    8

// Memory port widths
`define ADDR_W       27
`define TOKEN_W      7

// Weight memory map, one word per address
`define EMBED_BASE   0      // token*EMBED_SIZE + k
`define W_IH_BASE    304    // row*EMBED_SIZE + k
`define W_HH_BASE    336    // row*HIDDEN_SIZE + j
`define B_IH_BASE    400
`define B_HH_BASE    408
`define MEM_WORDS    416

`endif

//--- design/rnn_pkg.sv
`default_nettype none

`include "rnn_defines.svh"

package rnn_pkg;

    typedef logic signed [`WORD_W-1:0] word_t;          // Signed Q8.8

    typedef word_t [`EMBED_SIZE-1:0] embed_vec_t;
    typedef word_t [`HIDDEN_SIZE-1:0] hidden_vec_t;

    typedef logic [$clog2(`HIDDEN_SIZE)-1:0] neuron_idx_t;
    typedef logic [`TOKEN_W-1:0] token_t;
    typedef logic [`ADDR_W-1:0] mem_addr_t;

    typedef struct packed {
        mem_addr_t addr;
        logic      read;                                // One-cycle strobe
    } mem_req_t;

    typedef struct packed {
        word_t data;
        logic  valid;                                   // One-cycle answer
    } mem_rsp_t;

    // Full product, arithmetic shift by the fraction, low word kept
    function automatic word_t mul_q(input word_t a, input word_t b);
        logic signed [2*`WORD_W-1:0] prod;
        prod = a * b;
        return word_t'(prod >>> `FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

//--- design/rnn_step_ctrl.sv
`default_nettype none

`include "rnn_defines.svh"

module rnn_step_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                execute,
    input  rnn_pkg::token_t     token,
    input  rnn_pkg::mem_rsp_t   mem_a_rsp,
    input  rnn_pkg::mem_req_t   ih_req,
    input  logic                neuron_done,
    output rnn_pkg::mem_req_t   mem_a_req,
    output rnn_pkg::mem_rsp_t   ih_rsp,
    output rnn_pkg::embed_vec_t embedding,
    output logic                start,
    output rnn_pkg::neuron_idx_t row,
    output logic                commit,
    output logic                done
);
    import rnn_pkg::*;

    localparam int EMB_W = $clog2(`EMBED_SIZE);

    typedef enum logic [2:0] {
        S_IDLE,
        S_EMB_REQ,
        S_EMB_WAIT,
        S_ROW_START,
        S_ROW_WAIT,
        S_COMMIT,
        S_DONE
    } state_t;

    state_t           state;
    state_t           next_state;
    token_t           token_q;
    logic [EMB_W-1:0] emb_cnt;
    mem_addr_t        fetch_addr;
    logic             fetch_phase;
    logic             a_pending;

    assign fetch_addr = mem_addr_t'(`EMBED_BASE + token_q * `EMBED_SIZE + emb_cnt);
    assign fetch_phase = (state == S_EMB_REQ) || (state == S_EMB_WAIT);

    assign start = (state == S_ROW_START);
    assign commit = (state == S_COMMIT);
    assign done = (state == S_DONE);

    // Port A belongs to the embedding fetch first, then to the input path
    always_comb
    begin
        if (fetch_phase)
        begin
            mem_a_req.addr = fetch_addr;
            mem_a_req.read = (state == S_EMB_REQ);
            ih_rsp = '0;
        end
        else
        begin
            mem_a_req = ih_req;
            ih_rsp = mem_a_rsp;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if (execute)
                    next_state = S_EMB_REQ;
            end
            S_EMB_REQ:   next_state = S_EMB_WAIT;
            S_EMB_WAIT:
            begin
                if (mem_a_rsp.valid)
                    next_state = (emb_cnt == EMB_W'(`EMBED_SIZE - 1)) ? S_ROW_START : S_EMB_REQ;
            end
            S_ROW_START: next_state = S_ROW_WAIT;
            S_ROW_WAIT:
            begin
                if (neuron_done)
                    next_state = (row == neuron_idx_t'(`HIDDEN_SIZE - 1)) ? S_COMMIT : S_ROW_START;
            end
            S_COMMIT:    next_state = S_DONE;
            S_DONE:      next_state = S_IDLE;
            default:     next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            emb_cnt <= '0;
            row <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == S_IDLE && execute)
            begin
                emb_cnt <= '0;
                row <= '0;
            end
            if (state == S_EMB_WAIT && mem_a_rsp.valid)
                emb_cnt <= emb_cnt + 1'b1;
            if (state == S_ROW_WAIT && neuron_done)
                row <= row + 1'b1;                      // Wraps to 0 after the last row
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && execute)
            token_q <= token;                           // Held for the whole step
        if (state == S_EMB_WAIT && mem_a_rsp.valid)
            embedding[emb_cnt] <= mem_a_rsp.data;
    end

    // Tracks the single read allowed on port A, whoever issued it
    always_ff @(posedge clk)
    begin
        if (reset)
            a_pending <= 1'b0;
        else if (mem_a_req.read)
            a_pending <= 1'b1;
        else if (mem_a_rsp.valid)
            a_pending <= 1'b0;
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        mem_a_req.read |-> !a_pending);

endmodule

`default_nettype wire

//--- design/dot_path.sv
`default_nettype none

`include "rnn_defines.svh"

module dot_path #(
    parameter type vec_t       = rnn_pkg::embed_vec_t,
    parameter int  LENGTH      = `EMBED_SIZE,
    parameter int  WEIGHT_BASE = `W_IH_BASE,
    parameter int  BIAS_BASE   = `B_IH_BASE
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  rnn_pkg::neuron_idx_t row,
    input  vec_t                 operand,
    input  rnn_pkg::mem_rsp_t    mem_rsp,
    output rnn_pkg::mem_req_t    mem_req,
    output rnn_pkg::word_t       result,
    output logic                 result_valid
);
    import rnn_pkg::*;

    localparam int IDX_W = (LENGTH > 1) ? $clog2(LENGTH) : 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_MAC,
        S_BREQ,
        S_BWAIT,
        S_RESULT
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [IDX_W-1:0] idx;
    word_t            weight_q;
    word_t            acc;
    word_t            result_q;
    mem_addr_t        weight_addr;
    mem_addr_t        bias_addr;

    assign weight_addr = mem_addr_t'(WEIGHT_BASE + row * LENGTH + idx);
    assign bias_addr = mem_addr_t'(BIAS_BASE + row);

    always_comb
    begin
        mem_req.read = (state == S_REQ) || (state == S_BREQ);
        if (state == S_BREQ)
            mem_req.addr = bias_addr;
        else
            mem_req.addr = weight_addr;
    end

    assign result = result_q;
    assign result_valid = (state == S_RESULT);

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if (start)
                    next_state = S_REQ;
            end
            S_REQ:    next_state = S_WAIT;
            S_WAIT:
            begin
                if (mem_rsp.valid)
                    next_state = S_MAC;
            end
            S_MAC:    next_state = (idx == IDX_W'(LENGTH - 1)) ? S_BREQ : S_REQ;
            S_BREQ:   next_state = S_BWAIT;
            S_BWAIT:
            begin
                if (mem_rsp.valid)
                    next_state = S_RESULT;
            end
            S_RESULT: next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (start)
                begin
                    idx <= '0;
                    acc <= '0;
                end
            end
            S_WAIT:
            begin
                if (mem_rsp.valid)
                    weight_q <= mem_rsp.data;
            end
            S_MAC:
            begin
                acc <= acc + mul_q(weight_q, operand[idx]);     // Wraps modulo 2^16
                idx <= idx + 1'b1;
            end
            S_BWAIT:
            begin
                if (mem_rsp.valid)
                    result_q <= acc + mem_rsp.data;
            end
            default: ;
        endcase
    end

    rsp_only_when_waiting: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.valid |-> (state == S_WAIT || state == S_BWAIT));

    start_only_when_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> state == S_IDLE);

endmodule

`default_nettype wire

//--- design/hidden_update.sv
`default_nettype none

module hidden_update (
    input  logic                  clk,
    input  logic                  reset,
    input  rnn_pkg::word_t        ih_result,
    input  logic                  ih_valid,
    input  rnn_pkg::word_t        hh_result,
    input  logic                  hh_valid,
    input  rnn_pkg::neuron_idx_t  row,
    input  logic                  commit,
    output logic                  neuron_done,
    output rnn_pkg::hidden_vec_t  hidden_state
);
    import rnn_pkg::*;

    logic        ih_pend;
    logic        hh_pend;
    word_t       ih_q;
    word_t       hh_q;
    hidden_vec_t new_vec;
    hidden_vec_t old_vec;

    // Both path results held, neuron is written this cycle
    assign neuron_done = ih_pend && hh_pend;
    assign hidden_state = old_vec;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ih_pend <= 1'b0;
            hh_pend <= 1'b0;
            old_vec <= '0;
        end
        else
        begin
            if (ih_valid)
                ih_pend <= 1'b1;
            else if (neuron_done)
                ih_pend <= 1'b0;
            if (hh_valid)
                hh_pend <= 1'b1;
            else if (neuron_done)
                hh_pend <= 1'b0;
            if (commit)
                old_vec <= new_vec;                     // Visible from the next cycle on
        end
    end

    always_ff @(posedge clk)
    begin
        if (ih_valid)
            ih_q <= ih_result;
        if (hh_valid)
            hh_q <= hh_result;
        if (neuron_done)
            new_vec[row] <= ih_q + hh_q;
    end

    no_ih_overrun: assert property (@(posedge clk) disable iff (reset)
        ih_valid |-> !ih_pend);

    no_hh_overrun: assert property (@(posedge clk) disable iff (reset)
        hh_valid |-> !hh_pend);

endmodule

`default_nettype wire

//--- design/rnn_step_top.sv
`default_nettype none

`include "rnn_defines.svh"

module rnn_step_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 execute,
    input  rnn_pkg::token_t      token,
    output rnn_pkg::mem_req_t    mem_a_req,
    input  rnn_pkg::mem_rsp_t    mem_a_rsp,
    output rnn_pkg::mem_req_t    mem_b_req,
    input  rnn_pkg::mem_rsp_t    mem_b_rsp,
    output rnn_pkg::hidden_vec_t hidden_state,
    output logic                 done
);
    import rnn_pkg::*;

    mem_req_t    ih_req;
    mem_rsp_t    ih_rsp;
    embed_vec_t  embedding;
    logic        start;
    neuron_idx_t row;
    word_t       ih_result;
    logic        ih_valid;
    word_t       hh_result;
    logic        hh_valid;
    logic        neuron_done;
    logic        commit;

    rnn_step_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .execute     (execute),
        .token       (token),
        .mem_a_rsp   (mem_a_rsp),
        .ih_req      (ih_req),
        .neuron_done (neuron_done),
        .mem_a_req   (mem_a_req),
        .ih_rsp      (ih_rsp),
        .embedding   (embedding),
        .start       (start),
        .row         (row),
        .commit      (commit),
        .done        (done)
    );

    // Input path, shares port A through the sequencer
    dot_path #(
        .vec_t       (embed_vec_t),
        .LENGTH      (`EMBED_SIZE),
        .WEIGHT_BASE (`W_IH_BASE),
        .BIAS_BASE   (`B_IH_BASE)
    ) u_ih_path (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .row          (row),
        .operand      (embedding),
        .mem_rsp      (ih_rsp),
        .mem_req      (ih_req),
        .result       (ih_result),
        .result_valid (ih_valid)
    );

    // Recurrent path, owns port B
    dot_path #(
        .vec_t       (hidden_vec_t),
        .LENGTH      (`HIDDEN_SIZE),
        .WEIGHT_BASE (`W_HH_BASE),
        .BIAS_BASE   (`B_HH_BASE)
    ) u_hh_path (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .row          (row),
        .operand      (hidden_state),
        .mem_rsp      (mem_b_rsp),
        .mem_req      (mem_b_req),
        .result       (hh_result),
        .result_valid (hh_valid)
    );

    hidden_update u_update (
        .clk          (clk),
        .reset        (reset),
        .ih_result    (ih_result),
        .ih_valid     (ih_valid),
        .hh_result    (hh_result),
        .hh_valid     (hh_valid),
        .row          (row),
        .commit       (commit),
        .neuron_done  (neuron_done),
        .hidden_state (hidden_state)
    );

endmodule

`default_nettype wire

//--- tb/tb_rnn_mem.sv
`default_nettype none

`include "rnn_defines.svh"

module tb_rnn_mem (
    input  logic              clk,
    input  logic              reset,
    input  rnn_pkg::mem_req_t a_req,
    output rnn_pkg::mem_rsp_t a_rsp,
    input  rnn_pkg::mem_req_t b_req,
    output rnn_pkg::mem_rsp_t b_rsp
);
    import rnn_pkg::*;

    integer    seed = 32'h87;
    integer    lat;
    word_t     mem [0:`MEM_WORDS-1];
    mem_addr_t a_addr;
    mem_addr_t b_addr;
    logic      a_busy;
    logic      b_busy;
    logic [1:0] a_cnt;
    logic [1:0] b_cnt;

    // Contents depend on the whole address
    initial
    begin
        a_rsp = '0;
        b_rsp = '0;
        for (int i = 0; i < `MEM_WORDS; i++)
            mem[i] = word_t'(((i * 37 + 11) % 512) - 256);
    end

    function automatic word_t read_word(input mem_addr_t addr);
        if (addr < `MEM_WORDS)
            return mem[addr];
        return '0;
    endfunction

    // Both ports draw from one latency sequence
    always @(posedge clk)
    begin
        if (reset)
        begin
            a_busy <= 1'b0;
            b_busy <= 1'b0;
            a_rsp <= '0;
            b_rsp <= '0;
        end
        else
        begin
            a_rsp.valid <= 1'b0;
            b_rsp.valid <= 1'b0;
            if (a_busy)
            begin
                if (a_cnt == 0)
                begin
                    a_rsp.valid <= 1'b1;
                    a_rsp.data <= read_word(a_addr);
                    a_busy <= 1'b0;
                end
                else
                    a_cnt <= a_cnt - 1'b1;
            end
            if (a_req.read)
            begin
                lat = $random(seed);
                a_busy <= 1'b1;
                a_addr <= a_req.addr;
                a_cnt <= lat[1:0];                      // Answer after 1 to 4 cycles
            end
            if (b_busy)
            begin
                if (b_cnt == 0)
                begin
                    b_rsp.valid <= 1'b1;
                    b_rsp.data <= read_word(b_addr);
                    b_busy <= 1'b0;
                end
                else
                    b_cnt <= b_cnt - 1'b1;
            end
            if (b_req.read)
            begin
                lat = $random(seed);
                b_busy <= 1'b1;
                b_addr <= b_req.addr;
                b_cnt <= lat[1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_rnn_step.sv
`default_nettype none

`include "rnn_defines.svh"

module tb_rnn_step;
    import rnn_pkg::*;

    logic        clk;
    logic        reset;
    logic        execute;
    token_t      token;
    mem_req_t    mem_a_req;
    mem_rsp_t    mem_a_rsp;
    mem_req_t    mem_b_req;
    mem_rsp_t    mem_b_rsp;
    hidden_vec_t hidden_state;
    logic        done;

    token_t      tok_q[$];
    hidden_vec_t exp_q[$];
    token_t      cur_token;
    logic        started;
    logic        a_out;
    logic        b_out;
    int          value_errors = 0;
    int          proto_errors = 0;
    int          done_count = 0;
    int          cycles = 0;
    int          limit = 0;

    rnn_step_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .execute      (execute),
        .token        (token),
        .mem_a_req    (mem_a_req),
        .mem_a_rsp    (mem_a_rsp),
        .mem_b_req    (mem_b_req),
        .mem_b_rsp    (mem_b_rsp),
        .hidden_state (hidden_state),
        .done         (done)
    );

    tb_rnn_mem u_mem (
        .clk   (clk),
        .reset (reset),
        .a_req (mem_a_req),
        .a_rsp (mem_a_rsp),
        .b_req (mem_b_req),
        .b_rsp (mem_b_rsp)
    );

    initial
        clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_hidden(input hidden_vec_t got, input hidden_vec_t exp, input string what);
        for (int n = 0; n < `HIDDEN_SIZE; n++)
        begin
            if (got[n] !== exp[n])
            begin
                $display("ERR t=%0t %s neuron %0d got %h expected %h", $time, what, n, got[n],
                    exp[n]);
                value_errors++;
            end
        end
    endtask

    // Each port may only touch its own regions of the memory map
    task automatic check_req(input mem_req_t req, input logic port_b);
        int  a;
        logic ok;
        a = int'(req.addr);
        if (port_b)
            ok = (a >= `W_HH_BASE && a < `B_IH_BASE) || (a >= `B_HH_BASE && a < `MEM_WORDS);
        else
            ok = (a >= cur_token * `EMBED_SIZE && a < (cur_token + 1) * `EMBED_SIZE)
                || (a >= `W_IH_BASE && a < `W_HH_BASE)
                || (a >= `B_IH_BASE && a < `B_HH_BASE);
        if (!ok)
        begin
            $display("ERR t=%0t port %s read outside its regions at address %0d", $time,
                port_b ? "B" : "A", a);
            value_errors++;
        end
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        logic [15:0] tok;
        word_t       w [0:7];
        hidden_vec_t v;
        fd = $fopen("tb/rnn_step_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the pattern file");
            proto_errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", tok, w[0], w[1], w[2],
                        w[3], w[4], w[5], w[6], w[7]);
                    if (n == 9)
                    begin
                        for (int k = 0; k < `HIDDEN_SIZE; k++)
                            v[k] = w[k];
                        tok_q.push_back(token_t'(tok));
                        exp_q.push_back(v);
                    end
                end
            end
            $fclose(fd);
            if (tok_q.size() == 0)
            begin
                $display("The pattern file holds no steps");
                proto_errors++;
            end
        end
    endtask

    task automatic wait_done();
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!done);
    endtask

    // Protocol monitor sampling at the clock edge
    always @(posedge clk)
    begin
        if (reset)
        begin
            a_out <= 1'b0;
            b_out <= 1'b0;
        end
        else
        begin
            if ((mem_a_req.read || mem_b_req.read) && !started)
            begin
                $display("A memory read appeared before any execute");
                proto_errors++;
            end
            if (mem_a_req.read)
            begin
                check_req(mem_a_req, 1'b0);
                if (a_out)
                begin
                    $display("Two reads outstanding on port A");
                    proto_errors++;
                end
                a_out <= 1'b1;
            end
            else if (mem_a_rsp.valid)
                a_out <= 1'b0;
            if (mem_b_req.read)
            begin
                check_req(mem_b_req, 1'b1);
                if (b_out)
                begin
                    $display("Two reads outstanding on port B");
                    proto_errors++;
                end
                b_out <= 1'b1;
            end
            else if (mem_b_rsp.valid)
                b_out <= 1'b0;
            if (done)
                done_count++;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (limit != 0 && cycles >= limit)
        begin
            $display("Timeout, the run did not finish within %0d cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        reset = 1'b1;
        execute = 1'b0;
        token = '0;
        cur_token = '0;
        started = 1'b0;
        read_patterns();
        limit = tok_q.size() * 1200 + 200;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;

        // Quiet state after reset
        repeat (5) @(posedge clk);
        #1;
        check_hidden(hidden_state, '0, "after reset");
        if (done !== 1'b0)
        begin
            $display("done is not low after reset");
            proto_errors++;
        end

        for (int i = 0; i < tok_q.size(); i++)
        begin
            @(posedge clk);
            #2;
            token = tok_q[i];
            cur_token = tok_q[i];
            execute = 1'b1;
            started = 1'b1;
            @(posedge clk);
            #2 execute = 1'b0;
            if (i == 1)
            begin
                repeat (25) @(posedge clk);
                #2;
                token = token_t'(5);                    // Must be ignored mid step
                execute = 1'b1;
                @(posedge clk);
                #2;
                execute = 1'b0;
                token = tok_q[i];
            end
            wait_done();
            check_hidden(hidden_state, exp_q[i], $sformatf("step %0d", i));
            repeat (20) @(posedge clk);
            if (done_count != i + 1)
            begin
                $display("Expected %0d done pulses but saw %0d", i + 1, done_count);
                proto_errors++;
            end
        end

        $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/rnn_step_patterns.txt
# token h0 h1 h2 h3 h4 h5 h6 h7, all hex, hidden words signed Q8.8
# each line starts from the hidden vector of the line before, the first from zero
00 016D FFEC FE7F FF75 0193 0026 FEB9 013A
00 017E 01DD FEDF FF03 025B 0001 FC5D 0164

//--- files.f
+incdir+include
design/rnn_pkg.sv
design/rnn_step_ctrl.sv
design/dot_path.sv
design/hidden_update.sv
design/rnn_step_top.sv
tb/tb_rnn_mem.sv
tb/tb_rnn_step.sv
